// File: hw/uart_defines.svh
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// serial timing
`define CLKS_PER_BIT 8   // clocks per bit on the line
`define SYNC_STAGES  3   // rx input synchronizer depth

// register byte offsets on the AXI4-Lite port
`define ADDR_CTRL   4'h0   // parity enable, odd parity
`define ADDR_STATUS 4'h4   // busy, valid and error flags
`define ADDR_TXDATA 4'h8   // write starts a frame
`define ADDR_RXDATA 4'hC   // read clears rx status

`endif

// File: hw/uart_pkg.sv
package uart_pkg;

	typedef logic [7:0] uart_byte_t;   // one serial data byte
	typedef logic [3:0] reg_addr_t;    // register byte offset
	typedef logic [1:0] axi_resp_t;    // AXI response code

	localparam axi_resp_t RESP_OKAY   = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_PARITY,
		TX_STOP
	} tx_state_t;

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_PARITY,
		RX_STOP
	} rx_state_t;

endpackage

// File: hw/uart_tx.sv
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_tx import uart_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       i_start,
	input  uart_byte_t i_data,
	input  logic       i_parity_en,
	input  logic       i_parity_odd,
	output logic       o_busy,
	output logic       o_tx
);

	localparam int CNT_W = $clog2(`CLKS_PER_BIT + 1);

	tx_state_t        state;
	logic [CNT_W-1:0] baud_cnt;
	logic [2:0]       bit_idx;     // data bit being sent
	uart_byte_t       shift_reg;
	logic             parity_bit;
	logic             parity_en_q; // held for the whole frame
	logic             bit_end;

	assign bit_end = (baud_cnt == CNT_W'(`CLKS_PER_BIT - 1));

	always_ff @(posedge clk) begin
		if (reset || state == TX_IDLE || bit_end) begin
			baud_cnt <= '0;
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= TX_IDLE;
			o_busy      <= 1'b0;
			o_tx        <= 1'b1;   // line idles high
			bit_idx     <= '0;
			parity_en_q <= 1'b0;
		end else begin
			case (state)
				TX_IDLE: if (i_start) begin
					state       <= TX_START;
					o_busy      <= 1'b1;
					o_tx        <= 1'b0;   // start bit
					parity_en_q <= i_parity_en;
				end
				TX_START: if (bit_end) begin
					state   <= TX_DATA;
					o_tx    <= shift_reg[0];
					bit_idx <= '0;
				end
				TX_DATA: if (bit_end) begin
					if (bit_idx == 3'd7) begin
						if (parity_en_q) begin
							state <= TX_PARITY;
							o_tx  <= parity_bit;
						end else begin
							state <= TX_STOP;
							o_tx  <= 1'b1;
						end
					end else begin
						o_tx    <= shift_reg[0];   // lsb first
						bit_idx <= bit_idx + 1'b1;
					end
				end
				TX_PARITY: if (bit_end) begin
					state <= TX_STOP;
					o_tx  <= 1'b1;   // stop bit
				end
				TX_STOP: if (bit_end) begin
					state  <= TX_IDLE;
					o_busy <= 1'b0;
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == TX_IDLE && i_start) begin
			shift_reg  <= i_data;
			parity_bit <= ^i_data ^ i_parity_odd;   // even parity unless odd set
		end else if (bit_end && (state == TX_START || state == TX_DATA)) begin
			shift_reg <= {1'b0, shift_reg[7:1]};
		end
	end

	// register block must hold off a new frame until busy drops
	a_no_start_when_busy: assert property (@(posedge clk) disable iff (reset)
		i_start |-> !o_busy);

	a_idle_line_high: assert property (@(posedge clk) disable iff (reset)
		(state == TX_IDLE) |-> o_tx);

endmodule

// File: hw/uart_rx.sv
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_rx import uart_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       i_rx,
	input  logic       i_parity_en,
	input  logic       i_parity_odd,
	output logic       o_done,
	output uart_byte_t o_data,
	output logic       o_parity_err,
	output logic       o_frame_err
);

	localparam int CNT_W = $clog2(`CLKS_PER_BIT + 1);
	localparam int HALF  = (`CLKS_PER_BIT / 2 > 0) ? `CLKS_PER_BIT / 2 : 1;

	rx_state_t               state;
	logic [`SYNC_STAGES-1:0] sync_q;
	logic                    rx_s;       // synchronized line
	logic                    rx_prev;    // for falling edge
	logic [CNT_W-1:0]        baud_cnt;
	logic [2:0]              bit_idx;
	uart_byte_t              data_q;
	logic                    par_err_q;
	logic                    mid_start;
	logic                    bit_end;
	logic                    sample;     // mid-bit strobe

	assign rx_s      = sync_q[`SYNC_STAGES-1];
	assign mid_start = (baud_cnt == CNT_W'(HALF - 1));
	assign bit_end   = (baud_cnt == CNT_W'(`CLKS_PER_BIT - 1));
	// first strobe lands half a bit in, the rest one bit apart
	assign sample    = (state == RX_START) ? mid_start : bit_end;

	always_ff @(posedge clk) begin
		if (reset) begin
			sync_q  <= '1;
			rx_prev <= 1'b1;
		end else begin
			sync_q  <= {sync_q[`SYNC_STAGES-2:0], i_rx};
			rx_prev <= rx_s;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || state == RX_IDLE || sample) begin
			baud_cnt <= '0;   // restarts on each start edge
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state        <= RX_IDLE;
			bit_idx      <= '0;
			par_err_q    <= 1'b0;
			o_done       <= 1'b0;
			o_parity_err <= 1'b0;
			o_frame_err  <= 1'b0;
		end else begin
			o_done <= 1'b0;
			case (state)
				RX_IDLE: if (rx_prev && !rx_s) begin
					state     <= RX_START;
					par_err_q <= 1'b0;
				end
				RX_START: if (sample) begin
					state   <= rx_s ? RX_IDLE : RX_DATA;   // glitch goes back
					bit_idx <= '0;
				end
				RX_DATA: if (sample) begin
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7) begin
						state <= i_parity_en ? RX_PARITY : RX_STOP;
					end
				end
				RX_PARITY: if (sample) begin
					par_err_q <= rx_s ^ (^data_q) ^ i_parity_odd;
					state     <= RX_STOP;
				end
				RX_STOP: if (sample) begin
					o_done       <= 1'b1;
					o_parity_err <= par_err_q;
					o_frame_err  <= !rx_s;   // stop bit must be high
					state        <= RX_IDLE;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == RX_DATA && sample) begin
			data_q <= {rx_s, data_q[7:1]};   // lsb arrives first
		end
		if (state == RX_STOP && sample) begin
			o_data <= data_q;
		end
	end

	a_done_single_pulse: assert property (@(posedge clk) disable iff (reset)
		o_done |=> !o_done);

endmodule

// File: hw/uart_regs.sv
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_regs import uart_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        i_awvalid,
	output logic        o_awready,
	input  reg_addr_t   i_awaddr,
	input  logic        i_wvalid,
	output logic        o_wready,
	input  logic [31:0] i_wdata,
	output logic        o_bvalid,
	input  logic        i_bready,
	output axi_resp_t   o_bresp,
	input  logic        i_arvalid,
	output logic        o_arready,
	input  reg_addr_t   i_araddr,
	output logic        o_rvalid,
	input  logic        i_rready,
	output logic [31:0] o_rdata,
	output axi_resp_t   o_rresp,
	output logic        o_tx_start,
	output uart_byte_t  o_tx_data,
	input  logic        i_tx_busy,
	input  logic        i_rx_done,
	input  uart_byte_t  i_rx_data,
	input  logic        i_rx_parity_err,
	input  logic        i_rx_frame_err,
	output logic        o_parity_en,
	output logic        o_parity_odd
);

	logic       wr_accept;
	logic       rd_accept;
	logic       rd_rxdata;    // accepted read of RXDATA
	logic       rx_keep;      // status survives this cycle
	logic       tx_busy_any;
	logic       rx_valid;
	logic       parity_err;
	logic       frame_err;
	logic       overrun;
	uart_byte_t rx_data;

	assign wr_accept   = i_awvalid && i_wvalid && !o_bvalid;
	assign rd_accept   = i_arvalid && !o_rvalid;
	assign o_awready   = wr_accept;
	assign o_wready    = wr_accept;
	assign o_arready   = rd_accept;
	assign rd_rxdata   = rd_accept && (i_araddr == `ADDR_RXDATA);
	assign rx_keep     = !rd_rxdata;
	// busy also covers the cycle of the start pulse, before tx reacts
	assign tx_busy_any = i_tx_busy || o_tx_start;

	always_ff @(posedge clk) begin
		if (reset) begin
			o_bvalid     <= 1'b0;
			o_tx_start   <= 1'b0;
			o_parity_en  <= 1'b0;
			o_parity_odd <= 1'b0;
		end else begin
			o_tx_start <= 1'b0;
			if (wr_accept) begin
				o_bvalid <= 1'b1;
				if (i_awaddr == `ADDR_CTRL) begin
					o_parity_en  <= i_wdata[0];
					o_parity_odd <= i_wdata[1];
				end else if (i_awaddr == `ADDR_TXDATA && !tx_busy_any) begin
					o_tx_start <= 1'b1;
				end
			end else if (i_bready) begin
				o_bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_accept) begin
			o_tx_data <= i_wdata[7:0];
			if (i_awaddr == `ADDR_CTRL) begin
				o_bresp <= RESP_OKAY;
			end else if (i_awaddr == `ADDR_TXDATA && !tx_busy_any) begin
				o_bresp <= RESP_OKAY;
			end else begin
				o_bresp <= RESP_SLVERR;   // busy, read-only or unmapped
			end
		end
	end

	// sticky rx status, a new byte in the clearing cycle wins
	always_ff @(posedge clk) begin
		if (reset) begin
			rx_valid   <= 1'b0;
			parity_err <= 1'b0;
			frame_err  <= 1'b0;
			overrun    <= 1'b0;
			o_rvalid   <= 1'b0;
		end else begin
			rx_valid   <= i_rx_done || (rx_valid && rx_keep);
			parity_err <= (i_rx_done && i_rx_parity_err) || (parity_err && rx_keep);
			frame_err  <= (i_rx_done && i_rx_frame_err) || (frame_err && rx_keep);
			overrun    <= (i_rx_done && rx_valid && rx_keep) || (overrun && rx_keep);
			if (rd_accept) begin
				o_rvalid <= 1'b1;
			end else if (i_rready) begin
				o_rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_rx_done) begin
			rx_data <= i_rx_data;
		end
		if (rd_accept) begin
			o_rresp <= RESP_OKAY;
			case (i_araddr)
				`ADDR_CTRL:   o_rdata <= {30'd0, o_parity_odd, o_parity_en};
				`ADDR_STATUS: o_rdata <= {27'd0, overrun, frame_err, parity_err,
					rx_valid, tx_busy_any};
				`ADDR_RXDATA: o_rdata <= {24'd0, rx_data};
				default: begin
					o_rdata <= '0;
					o_rresp <= RESP_SLVERR;   // TXDATA is write only
				end
			endcase
		end
	end

	a_bvalid_held: assert property (@(posedge clk) disable iff (reset)
		o_bvalid && !i_bready |=> o_bvalid);

	a_rvalid_held: assert property (@(posedge clk) disable iff (reset)
		o_rvalid && !i_rready |=> o_rvalid);

endmodule

// File: hw/uart_top.sv
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_top import uart_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        i_awvalid,
	output logic        o_awready,
	input  reg_addr_t   i_awaddr,
	input  logic        i_wvalid,
	output logic        o_wready,
	input  logic [31:0] i_wdata,
	output logic        o_bvalid,
	input  logic        i_bready,
	output axi_resp_t   o_bresp,
	input  logic        i_arvalid,
	output logic        o_arready,
	input  reg_addr_t   i_araddr,
	output logic        o_rvalid,
	input  logic        i_rready,
	output logic [31:0] o_rdata,
	output axi_resp_t   o_rresp,
	input  logic        i_rx,
	output logic        o_tx
);

	logic       tx_start;
	uart_byte_t tx_data;
	logic       tx_busy;
	logic       rx_done;
	uart_byte_t rx_data;
	logic       rx_parity_err;
	logic       rx_frame_err;
	logic       parity_en;
	logic       parity_odd;   // shared by both serial sides

	uart_regs u_regs (
		.clk(clk), .reset(reset),
		.i_awvalid(i_awvalid), .o_awready(o_awready), .i_awaddr(i_awaddr),
		.i_wvalid(i_wvalid), .o_wready(o_wready), .i_wdata(i_wdata),
		.o_bvalid(o_bvalid), .i_bready(i_bready), .o_bresp(o_bresp),
		.i_arvalid(i_arvalid), .o_arready(o_arready), .i_araddr(i_araddr),
		.o_rvalid(o_rvalid), .i_rready(i_rready), .o_rdata(o_rdata), .o_rresp(o_rresp),
		.o_tx_start(tx_start), .o_tx_data(tx_data), .i_tx_busy(tx_busy),
		.i_rx_done(rx_done), .i_rx_data(rx_data),
		.i_rx_parity_err(rx_parity_err), .i_rx_frame_err(rx_frame_err),
		.o_parity_en(parity_en), .o_parity_odd(parity_odd)
	);

	uart_tx u_tx (
		.clk(clk), .reset(reset),
		.i_start(tx_start), .i_data(tx_data),
		.i_parity_en(parity_en), .i_parity_odd(parity_odd),
		.o_busy(tx_busy), .o_tx(o_tx)
	);

	uart_rx u_rx (
		.clk(clk), .reset(reset), .i_rx(i_rx),
		.i_parity_en(parity_en), .i_parity_odd(parity_odd),
		.o_done(rx_done), .o_data(rx_data),
		.o_parity_err(rx_parity_err), .o_frame_err(rx_frame_err)
	);

endmodule

// File: test/tb_uart_top.sv
`timescale 1ns/1ps
`include "uart_defines.svh"

module tb_uart_top import uart_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 40 * 12 * `CLKS_PER_BIT;

	logic        clk;
	logic        reset;
	logic        awvalid;
	logic        awready;
	reg_addr_t   awaddr;
	logic        wvalid;
	logic        wready;
	logic [31:0] wdata;
	logic        bvalid;
	logic        bready;
	axi_resp_t   bresp;
	logic        arvalid;
	logic        arready;
	reg_addr_t   araddr;
	logic        rvalid;
	logic        rready;
	logic [31:0] rdata_bus;
	axi_resp_t   rresp;
	logic        tx_line;
	logic        rx_line;
	logic        corrupt;       // flips one bit window on the loopback
	logic        tx_prev;
	logic        in_frame;
	int          bit_clk;       // clocks since the start edge
	int          frame_par;
	int          corrupt_win;   // -1 when the frame stays clean
	int          errors;
	int          cycles;

	assign rx_line = tx_line ^ corrupt;

	uart_top uut (
		.clk(clk), .reset(reset),
		.i_awvalid(awvalid), .o_awready(awready), .i_awaddr(awaddr),
		.i_wvalid(wvalid), .o_wready(wready), .i_wdata(wdata),
		.o_bvalid(bvalid), .i_bready(bready), .o_bresp(bresp),
		.i_arvalid(arvalid), .o_arready(arready), .i_araddr(araddr),
		.o_rvalid(rvalid), .i_rready(rready), .o_rdata(rdata_bus), .o_rresp(rresp),
		.i_rx(rx_line), .o_tx(tx_line)
	);

	always #5 clk = ~clk;

	// bit windows counted from the falling start edge seen on o_tx
	always @(posedge clk) begin
		#1;
		if (in_frame && bit_clk == (10 + frame_par) * `CLKS_PER_BIT - 1) begin
			in_frame = 1'b0;
		end else if (in_frame) begin
			bit_clk = bit_clk + 1;
		end else if (tx_prev && !tx_line) begin
			in_frame = 1'b1;
			bit_clk  = 0;
		end
		tx_prev = tx_line;
		corrupt = in_frame && (bit_clk / `CLKS_PER_BIT == corrupt_win);
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run still going after %0d clock cycles", TIMEOUT_CYCLES);
			$display("errors: %0d", errors);
			$display("test failed");
			$finish;
		end
	end

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			errors = errors + 1;
			$display("CHECK FAILED at time %0t: %s expected %h, got %h",
				$time, name, expected, actual);
		end
	endtask

	task automatic axi_write(input reg_addr_t addr, input logic [31:0] data,
		output axi_resp_t resp);
		logic accepted;
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		do begin
			@(negedge clk);   // ready is combinational, settled mid-cycle
			accepted = awready;
			check("awready", {31'd0, !bvalid}, {31'd0, awready});
			check("wready", {31'd0, !bvalid}, {31'd0, wready});
			@(posedge clk);
			#1;
		end while (!accepted);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		check("bvalid", 32'd1, {31'd0, bvalid});   // rises the cycle after accept
		resp = bresp;
		@(posedge clk);   // response waits while bready is low
		#1;
		check("bvalid held", 32'd1, {31'd0, bvalid});
		bready = 1'b1;
		@(posedge clk);
		#1;
		bready = 1'b0;
		check("bvalid after bready", 32'd0, {31'd0, bvalid});
	endtask

	task automatic axi_read(input reg_addr_t addr, output logic [31:0] data,
		output axi_resp_t resp);
		logic accepted;
		araddr  = addr;
		arvalid = 1'b1;
		do begin
			@(negedge clk);
			accepted = arready;
			check("arready", {31'd0, !rvalid}, {31'd0, arready});
			@(posedge clk);
			#1;
		end while (!accepted);
		arvalid = 1'b0;
		check("rvalid", 32'd1, {31'd0, rvalid});
		data = rdata_bus;
		resp = rresp;
		@(posedge clk);   // data waits while rready is low
		#1;
		check("rvalid held", 32'd1, {31'd0, rvalid});
		rready = 1'b1;
		@(posedge clk);
		#1;
		rready = 1'b0;
		check("rvalid after rready", 32'd0, {31'd0, rvalid});
	endtask

	// T sends and reads back, S sends only, B also writes TXDATA while busy
	task automatic run_frame(input logic [7:0] op, input logic [31:0] ctrl,
		input logic [31:0] data, input int win, input logic [31:0] exp_rx,
		input logic [31:0] exp_status, input logic [31:0] exp_resp);
		axi_resp_t   resp;
		logic [31:0] rdata;
		axi_write(`ADDR_CTRL, ctrl, resp);
		check("bresp CTRL", 32'(RESP_OKAY), 32'(resp));
		frame_par   = ctrl[0] ? 1 : 0;
		corrupt_win = win;
		axi_write(`ADDR_TXDATA, data, resp);
		check("bresp TXDATA", (op == "B") ? 32'(RESP_OKAY) : exp_resp, 32'(resp));
		axi_read(`ADDR_STATUS, rdata, resp);
		check("STATUS.tx_busy", 32'd1, {31'd0, rdata[0]});
		if (op == "B") begin
			axi_write(`ADDR_TXDATA, ~data, resp);
			check("bresp TXDATA while busy", exp_resp, 32'(resp));
		end
		do begin
			axi_read(`ADDR_STATUS, rdata, resp);
		end while (rdata[0]);
		do begin
			axi_read(`ADDR_STATUS, rdata, resp);
		end while (!rdata[1]);
		axi_read(`ADDR_STATUS, rdata, resp);
		check("STATUS", exp_status, rdata);
		if (op != "S") begin
			axi_read(`ADDR_RXDATA, rdata, resp);
			check("RXDATA", exp_rx, rdata);
			axi_read(`ADDR_STATUS, rdata, resp);
			check("STATUS after RXDATA read", 32'd0, rdata);
		end
		corrupt_win = -1;
	endtask

	initial begin
		int          fd;
		int          n;
		int          win;
		int          lines_run;
		string       line;
		logic [7:0]  op;
		logic [31:0] none_s;
		logic [31:0] ctrl;
		logic [31:0] data;
		logic [31:0] exp_rx;
		logic [31:0] exp_st;
		logic [31:0] exp_rsp;
		logic [31:0] rdata;
		axi_resp_t   resp;
		clk = 1'b0;
		reset = 1'b1;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		corrupt = 1'b0;
		tx_prev = 1'b1;
		in_frame = 1'b0;
		bit_clk = 0;
		frame_par = 0;
		corrupt_win = -1;
		errors = 0;
		cycles = 0;
		lines_run = 0;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		fd = $fopen("test/uart_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open test/uart_golden.txt");
			errors = errors + 1;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (line.len() < 2 || line[0] == "#") continue;
				n = $sscanf(line, "%s %h %h %d %h %h %h", op, ctrl, data, win,
					exp_rx, exp_st, exp_rsp);
				if (n != 7) begin   // corrupt column may read none
					n = $sscanf(line, "%s %h %h %s %h %h %h", op, ctrl, data, none_s,
						exp_rx, exp_st, exp_rsp);
					win = -1;
					if (n != 7 || none_s != "none") begin
						$display("unreadable line in golden file: %s", line);
						errors = errors + 1;
						continue;
					end
				end
				case (op)
					"T", "S", "B": run_frame(op, ctrl, data, win, exp_rx, exp_st, exp_rsp);
					"W": begin
						axi_write(ctrl[3:0], data, resp);
						check("bresp", exp_rsp, 32'(resp));
					end
					"R": begin
						axi_read(ctrl[3:0], rdata, resp);
						check("rdata", exp_rx, rdata);
						check("rresp", exp_rsp, 32'(resp));
					end
					default: begin
						$display("unknown operation in golden file: %s", line);
						errors = errors + 1;
					end
				endcase
				lines_run = lines_run + 1;
			end
			$fclose(fd);
		end
		if (lines_run == 0) begin
			$display("golden file held no transactions");
			errors = errors + 1;
		end
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: test/uart_golden.txt
# op ctrl byte corrupt exp_rxdata exp_status exp_resp, hex except corrupt (bit window, 0 = start)
# op: T send and read back, S send only, B send then TXDATA while busy, W write reg, R read reg
T 0 55 none 55 02 0
T 0 00 none 00 02 0
T 0 ff none ff 02 0
T 1 a5 none a5 02 0
T 1 00 none 00 02 0
T 3 ff none ff 02 0
T 3 a5 none a5 02 0
T 1 3c 9 3c 06 0
T 3 3c 9 3c 06 0
T 1 a5 1 a4 06 0
T 3 81 8 01 06 0
T 0 5a 9 5a 0a 0
T 0 c3 none c3 02 0
T 1 96 10 96 0a 0
S 0 11 none 00 02 0
T 0 22 none 22 12 0
B 0 77 none 77 02 2
W 1 ff none 00 00 2
W 4 01 none 00 00 2
W c 01 none 00 00 2
W 0 03 none 00 00 0
R 0 00 none 03 00 0
R 8 00 none 00 00 2
R 6 00 none 00 00 2

// File: compile.f
+incdir+hw
hw/uart_pkg.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_regs.sv
hw/uart_top.sv
test/tb_uart_top.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_uart_top
RTL_TOP    = uart_top
FILELIST   = compile.f
OBJ_DIR    = obj_dir
LOG        = sim.log
SOURCES    = $(wildcard hw/*.sv hw/*.svh test/*.sv) test/uart_golden.txt

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the run fails when the log reports failure or never reports success
run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then exit 1; fi
	@if ! grep -q "test passed" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
